/* design/ext_subsys_settings.svh */
// Address map, bus widths and sizing for the external subsystem
// Included by the package and by every module that reads these values
`ifndef EXT_SUBSYS_SETTINGS_SVH
`define EXT_SUBSYS_SETTINGS_SVH

// Register bus
`define EXT_ADDR_W 32
`define EXT_DATA_W 32

// Power domains and switch cell behaviour
`define EXT_NUM_DOMAINS 4
`define SWITCH_ACK_LATENCY 15

// Slow memory depth in words
`define EXT_MEM_WORDS 128

// Address map with sizes in bytes
`define EXT_PWR_BASE 32'h0000_0000
`define EXT_PWR_SIZE 32'h0000_0010
`define EXT_MEM_BASE 32'h0000_1000
`define EXT_MEM_SIZE 32'h0000_0200

`endif

/* design/ext_subsys_pkg.sv */
// Shared types and encodings of the external subsystem
// Imported by the RTL modules and the bound properties
`include "ext_subsys_settings.svh"

package ext_subsys_pkg;

  typedef logic [`EXT_ADDR_W-1:0] addr_t;
  typedef logic [`EXT_DATA_W-1:0] word_t;
  typedef logic [`EXT_NUM_DOMAINS-1:0] domain_vec_t;

  // Decoded target of a bus request
  typedef enum logic [1:0] {
    TGT_PWR  = 2'd0,
    TGT_MEM  = 2'd1,
    TGT_NONE = 2'd2
  } bus_target_e;

  // Register index taken from address bits [3:2]
  typedef enum logic [1:0] {
    PWR_REG_SWITCH = 2'd0,
    PWR_REG_ACK    = 2'd1
  } pwr_reg_e;

  typedef enum logic [1:0] {
    MEM_IDLE = 2'd0,
    MEM_WAIT = 2'd1,
    MEM_RESP = 2'd2
  } mem_state_e;

endpackage

/* design/reg_bus_demux.sv */
// Routes register-bus requests to the power registers or the slow memory
// Unmapped addresses get a local error response one cycle after acceptance
`timescale 1ns/1ps
`include "ext_subsys_settings.svh"

module reg_bus_demux import ext_subsys_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_valid_i,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  word_t req_wdata_i,
  output logic  req_ready_o,
  output logic  rsp_valid_o,
  output word_t rsp_rdata_o,
  output logic  rsp_error_o,
  input  logic  rsp_ready_i,
  output logic  pwr_req_valid_o,
  output logic  pwr_req_write_o,
  output addr_t pwr_req_addr_o,
  output word_t pwr_req_wdata_o,
  input  logic  pwr_req_ready_i,
  input  logic  pwr_rsp_valid_i,
  input  word_t pwr_rsp_rdata_i,
  output logic  pwr_rsp_ready_o,
  output logic  mem_req_valid_o,
  output logic  mem_req_write_o,
  output addr_t mem_req_addr_o,
  output word_t mem_req_wdata_o,
  input  logic  mem_req_ready_i,
  input  logic  mem_rsp_valid_i,
  input  word_t mem_rsp_rdata_i,
  output logic  mem_rsp_ready_o
);

  addr_t       pwr_offset;
  addr_t       mem_offset;
  bus_target_e dec_tgt;
  bus_target_e tgt_q;
  logic        pending_q;
  logic        req_fire;
  logic        rsp_fire;

  // Offsets wrap below the base, so one compare covers both bounds
  assign pwr_offset = req_addr_i - `EXT_PWR_BASE;
  assign mem_offset = req_addr_i - `EXT_MEM_BASE;

  always_comb begin
    if (pwr_offset < `EXT_PWR_SIZE) begin
      dec_tgt = TGT_PWR;
    end else if (mem_offset < `EXT_MEM_SIZE) begin
      dec_tgt = TGT_MEM;
    end else begin
      dec_tgt = TGT_NONE;
    end
  end

  always_comb begin
    case (dec_tgt)
      TGT_PWR: req_ready_o = !pending_q && pwr_req_ready_i;
      TGT_MEM: req_ready_o = !pending_q && mem_req_ready_i;
      default: req_ready_o = !pending_q;
    endcase
  end

  assign pwr_req_valid_o = req_valid_i && !pending_q && (dec_tgt == TGT_PWR);
  assign pwr_req_write_o = req_write_i;
  assign pwr_req_addr_o  = pwr_offset;
  assign pwr_req_wdata_o = req_wdata_i;

  assign mem_req_valid_o = req_valid_i && !pending_q && (dec_tgt == TGT_MEM);
  assign mem_req_write_o = req_write_i;
  assign mem_req_addr_o  = mem_offset;
  assign mem_req_wdata_o = req_wdata_i;

  assign req_fire = req_valid_i && req_ready_o;
  assign rsp_fire = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
      tgt_q     <= TGT_NONE;
    end else if (req_fire) begin
      pending_q <= 1'b1;
      tgt_q     <= dec_tgt;
    end else if (rsp_fire) begin
      pending_q <= 1'b0;
    end
  end

  // Response comes back only from the target that took the request
  always_comb begin
    rsp_valid_o     = 1'b0;
    rsp_rdata_o     = '0;
    rsp_error_o     = 1'b0;
    pwr_rsp_ready_o = 1'b0;
    mem_rsp_ready_o = 1'b0;
    if (pending_q) begin
      case (tgt_q)
        TGT_PWR: begin
          rsp_valid_o     = pwr_rsp_valid_i;
          rsp_rdata_o     = pwr_rsp_rdata_i;
          pwr_rsp_ready_o = rsp_ready_i;
        end
        TGT_MEM: begin
          rsp_valid_o     = mem_rsp_valid_i;
          rsp_rdata_o     = mem_rsp_rdata_i;
          mem_rsp_ready_o = rsp_ready_i;
        end
        default: begin
          rsp_valid_o = 1'b1;
          rsp_error_o = 1'b1;
        end
      endcase
    end
  end

endmodule

/* design/power_ctrl_regs.sv */
// Power-gating control registers for the external domains
// Offset 0x0 holds the active-low switches, offset 0x4 reads back the acks
`timescale 1ns/1ps

module power_ctrl_regs import ext_subsys_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_valid_i,
  input  logic        req_write_i,
  input  addr_t       req_addr_i,
  input  word_t       req_wdata_i,
  output logic        req_ready_o,
  output logic        rsp_valid_o,
  output word_t       rsp_rdata_o,
  input  logic        rsp_ready_i,
  input  domain_vec_t pwr_ack_n_i,
  output domain_vec_t pwr_switch_n_o
);

  domain_vec_t switch_q;
  logic        rsp_valid_q;
  word_t       rdata_q;
  pwr_reg_e    reg_sel;
  logic        req_fire;

  assign reg_sel     = pwr_reg_e'(req_addr_i[3:2]);
  assign req_ready_o = !rsp_valid_q;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      switch_q    <= '1;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
      if (req_write_i && (reg_sel == PWR_REG_SWITCH)) begin
        switch_q <= req_wdata_i[$bits(domain_vec_t)-1:0];
      end
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Read data is sampled at acceptance and held with the response
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_write_i) begin
        rdata_q <= '0;
      end else begin
        case (reg_sel)
          PWR_REG_SWITCH: rdata_q <= word_t'(switch_q);
          PWR_REG_ACK:    rdata_q <= word_t'(pwr_ack_n_i);
          default:        rdata_q <= '0;
        endcase
      end
    end
  end

  assign rsp_valid_o    = rsp_valid_q;
  assign rsp_rdata_o    = rdata_q;
  assign pwr_switch_n_o = switch_q;

endmodule

/* design/switch_ack_model.sv */
// Stand-in for the power switch cells of the external domains
// Each switch state comes back as its acknowledge a fixed number of cycles later
`timescale 1ns/1ps
`include "ext_subsys_settings.svh"

module switch_ack_model import ext_subsys_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  domain_vec_t pwr_switch_n_i,
  output domain_vec_t pwr_ack_n_o
);

  domain_vec_t stage_q [`SWITCH_ACK_LATENCY];

  // All domains start off, so every stage resets to ones
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= pwr_switch_n_i;
      for (int i = 1; i < `SWITCH_ACK_LATENCY; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign pwr_ack_n_o = stage_q[`SWITCH_ACK_LATENCY-1];

endmodule

/* design/slow_memory.sv */
// Word memory with a response latency of 1 to 4 cycles
// The extra wait per access comes from a free-running LFSR
`timescale 1ns/1ps
`include "ext_subsys_settings.svh"

module slow_memory import ext_subsys_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  req_valid_i,
  input  logic  req_write_i,
  input  addr_t req_addr_i,
  input  word_t req_wdata_i,
  output logic  req_ready_o,
  output logic  rsp_valid_o,
  output word_t rsp_rdata_o,
  input  logic  rsp_ready_i
);

  localparam int IDX_W = $clog2(`EXT_MEM_WORDS);

  word_t             mem_q [`EXT_MEM_WORDS];
  mem_state_e        state_q;
  logic [1:0]        wait_q;
  logic [7:0]        lfsr_q;
  logic [IDX_W-1:0]  idx_q;
  logic              write_q;
  word_t             wdata_q;
  word_t             rdata_q;
  logic [IDX_W-1:0]  acc_idx;
  logic              acc_write;
  word_t             acc_wdata;
  logic              accept;
  logic              enter_resp;

  assign accept = req_valid_i && (state_q == MEM_IDLE);

  // x^8 + x^6 + x^5 + x^4 + 1
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lfsr_q <= 8'hE1;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // Zero wait goes straight to MEM_RESP using the live request
  always_comb begin
    if (state_q == MEM_IDLE) begin
      acc_idx   = req_addr_i[IDX_W+1:2];
      acc_write = req_write_i;
      acc_wdata = req_wdata_i;
    end else begin
      acc_idx   = idx_q;
      acc_write = write_q;
      acc_wdata = wdata_q;
    end
    enter_resp = (accept && (lfsr_q[1:0] == 2'd0)) ||
                 ((state_q == MEM_WAIT) && (wait_q == 2'd0));
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= MEM_IDLE;
      wait_q  <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (accept) begin
            if (lfsr_q[1:0] == 2'd0) begin
              state_q <= MEM_RESP;
            end else begin
              state_q <= MEM_WAIT;
              wait_q  <= lfsr_q[1:0] - 2'd1;
            end
          end
        end
        MEM_WAIT: begin
          if (wait_q == 2'd0) begin
            state_q <= MEM_RESP;
          end else begin
            wait_q <= wait_q - 2'd1;
          end
        end
        MEM_RESP: begin
          if (rsp_ready_i) begin
            state_q <= MEM_IDLE;
          end
        end
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      idx_q   <= req_addr_i[IDX_W+1:2];
      write_q <= req_write_i;
      wdata_q <= req_wdata_i;
    end
    if (enter_resp) begin
      if (acc_write) begin
        mem_q[acc_idx] <= acc_wdata;
        rdata_q        <= '0;
      end else begin
        rdata_q <= mem_q[acc_idx];
      end
    end
  end

  assign req_ready_o = (state_q == MEM_IDLE);
  assign rsp_valid_o = (state_q == MEM_RESP);
  assign rsp_rdata_o = rdata_q;

endmodule

/* design/ext_subsys.sv */
// External subsystem top with a single register-bus port
// Power switch and acknowledge vectors are brought out for observation
`timescale 1ns/1ps

module ext_subsys import ext_subsys_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        req_valid_i,
  input  logic        req_write_i,
  input  addr_t       req_addr_i,
  input  word_t       req_wdata_i,
  output logic        req_ready_o,
  output logic        rsp_valid_o,
  output word_t       rsp_rdata_o,
  output logic        rsp_error_o,
  input  logic        rsp_ready_i,
  output domain_vec_t pwr_switch_n_o,
  output domain_vec_t pwr_ack_n_o
);

  logic        pwr_req_valid;
  logic        pwr_req_write;
  addr_t       pwr_req_addr;
  word_t       pwr_req_wdata;
  logic        pwr_req_ready;
  logic        pwr_rsp_valid;
  word_t       pwr_rsp_rdata;
  logic        pwr_rsp_ready;
  logic        mem_req_valid;
  logic        mem_req_write;
  addr_t       mem_req_addr;
  word_t       mem_req_wdata;
  logic        mem_req_ready;
  logic        mem_rsp_valid;
  word_t       mem_rsp_rdata;
  logic        mem_rsp_ready;
  domain_vec_t pwr_switch_n;
  domain_vec_t pwr_ack_n;

  reg_bus_demux demux0 (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_write_i     (req_write_i),
    .req_addr_i      (req_addr_i),
    .req_wdata_i     (req_wdata_i),
    .req_ready_o     (req_ready_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_rdata_o     (rsp_rdata_o),
    .rsp_error_o     (rsp_error_o),
    .rsp_ready_i     (rsp_ready_i),
    .pwr_req_valid_o (pwr_req_valid),
    .pwr_req_write_o (pwr_req_write),
    .pwr_req_addr_o  (pwr_req_addr),
    .pwr_req_wdata_o (pwr_req_wdata),
    .pwr_req_ready_i (pwr_req_ready),
    .pwr_rsp_valid_i (pwr_rsp_valid),
    .pwr_rsp_rdata_i (pwr_rsp_rdata),
    .pwr_rsp_ready_o (pwr_rsp_ready),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_write_o (mem_req_write),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_wdata_o (mem_req_wdata),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_rdata_i (mem_rsp_rdata),
    .mem_rsp_ready_o (mem_rsp_ready)
  );

  power_ctrl_regs pwr_regs0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (pwr_req_valid),
    .req_write_i    (pwr_req_write),
    .req_addr_i     (pwr_req_addr),
    .req_wdata_i    (pwr_req_wdata),
    .req_ready_o    (pwr_req_ready),
    .rsp_valid_o    (pwr_rsp_valid),
    .rsp_rdata_o    (pwr_rsp_rdata),
    .rsp_ready_i    (pwr_rsp_ready),
    .pwr_ack_n_i    (pwr_ack_n),
    .pwr_switch_n_o (pwr_switch_n)
  );

  switch_ack_model ack_model0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .pwr_switch_n_i (pwr_switch_n),
    .pwr_ack_n_o    (pwr_ack_n)
  );

  slow_memory slow_ram0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (mem_req_valid),
    .req_write_i (mem_req_write),
    .req_addr_i  (mem_req_addr),
    .req_wdata_i (mem_req_wdata),
    .req_ready_o (mem_req_ready),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_rdata_o (mem_rsp_rdata),
    .rsp_ready_i (mem_rsp_ready)
  );

  assign pwr_switch_n_o = pwr_switch_n;
  assign pwr_ack_n_o    = pwr_ack_n;

endmodule

/* tb/ext_subsys_properties.sv */
// Handshake and switch acknowledge rules for the external subsystem
// Bound into ext_subsys and sampled on its top-level ports
`timescale 1ns/1ps
`include "ext_subsys_settings.svh"

module ext_subsys_properties import ext_subsys_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  input logic        req_valid_i,
  input logic        req_ready_o,
  input logic        rsp_valid_o,
  input word_t       rsp_rdata_o,
  input logic        rsp_error_o,
  input logic        rsp_ready_i,
  input domain_vec_t pwr_switch_n_o,
  input domain_vec_t pwr_ack_n_o
);

  logic        pending_q;
  int unsigned run_cycles_q;

  // Ack history is only valid once the delay line has refilled after reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q    <= 1'b0;
      run_cycles_q <= 0;
    end else begin
      if (run_cycles_q < `SWITCH_ACK_LATENCY) begin
        run_cycles_q <= run_cycles_q + 1;
      end
      if (req_valid_i && req_ready_o) begin
        pending_q <= 1'b1;
      end else if (rsp_valid_o && rsp_ready_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  rsp_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o))
    else $error("response changed while stalled");

  ready_low_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pending_q |-> !req_ready_o)
    else $error("request ready while a transaction is pending");

  ack_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (run_cycles_q >= `SWITCH_ACK_LATENCY) |->
      (pwr_ack_n_o == $past(pwr_switch_n_o, `SWITCH_ACK_LATENCY)))
    else $error("switch acknowledge does not follow the switch with the fixed latency");

endmodule

bind ext_subsys ext_subsys_properties props0 (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .req_valid_i    (req_valid_i),
  .req_ready_o    (req_ready_o),
  .rsp_valid_o    (rsp_valid_o),
  .rsp_rdata_o    (rsp_rdata_o),
  .rsp_error_o    (rsp_error_o),
  .rsp_ready_i    (rsp_ready_i),
  .pwr_switch_n_o (pwr_switch_n_o),
  .pwr_ack_n_o    (pwr_ack_n_o)
);

/* tb/tb_ext_subsys.sv */
// Directed testbench for the external subsystem
// Drives the register bus, checks responses and the power switch outputs
`timescale 1ns/1ps
`include "ext_subsys_settings.svh"

module tb_ext_subsys import ext_subsys_pkg::*; ();

  // All tests together need a few hundred cycles
  localparam int MAX_CYCLES = 5000;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_valid_i;
  logic        req_write_i;
  addr_t       req_addr_i;
  word_t       req_wdata_i;
  logic        req_ready_o;
  logic        rsp_valid_o;
  word_t       rsp_rdata_o;
  logic        rsp_error_o;
  logic        rsp_ready_i;
  domain_vec_t pwr_switch_n_o;
  domain_vec_t pwr_ack_n_o;

  integer      seed = 22418;
  int          cycle_count = 0;
  word_t       last_rdata;
  logic        last_error;
  int          last_latency;
  word_t       mem_model [`EXT_MEM_WORDS];
  logic [6:0]  written_idx [$];

  ext_subsys dut0 (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_valid_i    (req_valid_i),
    .req_write_i    (req_write_i),
    .req_addr_i     (req_addr_i),
    .req_wdata_i    (req_wdata_i),
    .req_ready_o    (req_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_rdata_o    (rsp_rdata_o),
    .rsp_error_o    (rsp_error_o),
    .rsp_ready_i    (rsp_ready_i),
    .pwr_switch_n_o (pwr_switch_n_o),
    .pwr_ack_n_o    (pwr_ack_n_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("TIMEOUT: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_value(input string test, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("CHECK FAILED: test %s expected 0x%08h actual 0x%08h", test, expected, actual);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic addr_t mem_word_addr(input logic [6:0] idx);
    return `EXT_MEM_BASE + {23'd0, idx, 2'b00};
  endfunction

  // Called just after a rising edge; returns just after the accepting edge
  task automatic send_request(input logic write, input addr_t addr, input word_t wdata);
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  // Stall holds rsp_ready_i low for that many cycles after valid shows
  task automatic take_response(input string name, input int stall);
    word_t held;
    last_latency = 0;
    rsp_ready_i  = (stall == 0);
    do begin
      @(negedge clk_i);
      last_latency++;
    end while (!rsp_valid_o);
    held       = rsp_rdata_o;
    last_error = rsp_error_o;
    for (int i = 1; i < stall; i++) begin
      @(negedge clk_i);
      check_value({name, " valid held"}, 32'd1, word_t'(rsp_valid_o));
      check_value({name, " data held"}, held, rsp_rdata_o);
      check_value({name, " ready low"}, 32'd0, word_t'(req_ready_o));
    end
    if (stall != 0) begin
      @(posedge clk_i);
      #1;
      rsp_ready_i = 1'b1;
    end
    @(posedge clk_i);
    #1;
    rsp_ready_i = 1'b0;
    last_rdata  = held;
  endtask

  task automatic bus_write(input string name, input addr_t addr, input word_t wdata);
    send_request(1'b1, addr, wdata);
    take_response(name, 0);
  endtask

  task automatic bus_read(input string name, input addr_t addr, input int stall);
    send_request(1'b0, addr, '0);
    take_response(name, stall);
  endtask

  task automatic test_reset_state();
    check_value("reset switch", 32'hF, word_t'(pwr_switch_n_o));
    check_value("reset ack", 32'hF, word_t'(pwr_ack_n_o));
    check_value("reset rsp_valid", 32'd0, word_t'(rsp_valid_o));
    check_value("reset req_ready", 32'd1, word_t'(req_ready_o));
    bus_read("reset read", `EXT_PWR_BASE, 0);
    check_value("reset read data", 32'hF, last_rdata);
    check_value("reset read error", 32'd0, word_t'(last_error));
    check_value("reset read latency", 32'd1, last_latency);
  endtask

  task automatic test_memory_round_trip();
    logic [6:0] idx;
    word_t      data;
    for (int i = 0; i < 16; i++) begin
      idx  = 7'($random(seed));
      data = word_t'($random(seed));
      bus_write("mem write", mem_word_addr(idx), data);
      check_value("mem write error", 32'd0, word_t'(last_error));
      check_value("mem write latency", 32'd1,
                  word_t'(last_latency >= 1 && last_latency <= 4));
      mem_model[idx] = data;
      written_idx.push_back(idx);
    end
    foreach (written_idx[i]) begin
      bus_read("mem read", mem_word_addr(written_idx[i]), 0);
      check_value("mem read data", mem_model[written_idx[i]], last_rdata);
      check_value("mem read error", 32'd0, word_t'(last_error));
      check_value("mem read latency", 32'd1,
                  word_t'(last_latency >= 1 && last_latency <= 4));
    end
  endtask

  task automatic test_power_switching();
    bus_write("switch write", `EXT_PWR_BASE, 32'h5);
    check_value("switch output", 32'h5, word_t'(pwr_switch_n_o));
    for (int i = 0; i < `SWITCH_ACK_LATENCY - 1; i++) begin
      @(negedge clk_i);
      check_value("ack before latency", 32'hF, word_t'(pwr_ack_n_o));
    end
    @(negedge clk_i);
    check_value("ack after latency", 32'h5, word_t'(pwr_ack_n_o));
    @(posedge clk_i);
    #1;
    bus_read("ack read", `EXT_PWR_BASE + 32'h4, 0);
    check_value("ack read data", 32'h5, last_rdata);
  endtask

  task automatic test_error_and_ignored();
    bus_read("unmapped read", 32'h0000_8000, 0);
    check_value("unmapped read error", 32'd1, word_t'(last_error));
    check_value("unmapped read data", 32'd0, last_rdata);
    check_value("unmapped read latency", 32'd1, last_latency);
    bus_write("unmapped write", 32'h0000_8000, 32'hDEAD_BEEF);
    check_value("unmapped write error", 32'd1, word_t'(last_error));
    check_value("unmapped write data", 32'd0, last_rdata);
    bus_write("ack write", `EXT_PWR_BASE + 32'h4, 32'hA);
    bus_read("ack reread", `EXT_PWR_BASE + 32'h4, 0);
    check_value("ack unchanged", 32'h5, last_rdata);
  endtask

  task automatic test_back_pressure();
    bus_read("mem stall", mem_word_addr(written_idx[0]), 6);
    check_value("mem stall data", mem_model[written_idx[0]], last_rdata);
    check_value("mem stall ready after", 32'd1, word_t'(req_ready_o));
    bus_read("reg stall", `EXT_PWR_BASE, 6);
    check_value("reg stall data", 32'h5, last_rdata);
    check_value("reg stall ready after", 32'd1, word_t'(req_ready_o));
  endtask

  initial begin
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    test_reset_state();
    test_memory_round_trip();
    test_power_switching();
    test_error_and_ignored();
    test_back_pressure();
    $display("Regression passed");
    $finish;
  end

endmodule

/* ext_subsys.f */
+incdir+design
design/ext_subsys_pkg.sv
design/reg_bus_demux.sv
design/power_ctrl_regs.sv
design/switch_ack_model.sv
design/slow_memory.sv
design/ext_subsys.sv
tb/ext_subsys_properties.sv
tb/tb_ext_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the external subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ext_subsys.f --top-module tb_ext_subsys -o tb_ext_subsys
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_ext_subsys)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "Regression passed"; then
  exit 0
fi
exit 1
